// File: verilog/tlb_pkg.sv
package tlb_pkg;

    // Geometry
    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = 4;

    // Page size codes, log2 of the page size
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_4m = 6'd21;

    // Invalidate operation codes
    localparam logic [4:0] inv_all0         = 5'd0;
    localparam logic [4:0] inv_all1         = 5'd1;
    localparam logic [4:0] inv_g1           = 5'd2;
    localparam logic [4:0] inv_g0           = 5'd3;
    localparam logic [4:0] inv_g0_asid      = 5'd4;
    localparam logic [4:0] inv_g0_asid_va   = 5'd5;
    localparam logic [4:0] inv_g_or_asid_va = 5'd6;

    // One page of an even/odd pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_half_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;  // va[31:13]
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        tlb_half_t   p0;    // Even page
        tlb_half_t   p1;    // Odd page
    } tlb_entry_t;

    typedef struct packed {
        logic                 we;
        logic [tlb_idx_w-1:0] index;
        tlb_entry_t           entry;
    } tlb_wr_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  op;
        logic [9:0]  asid;
        logic [18:0] vppn;
    } tlb_inv_t;

    // Search result, ps kept for the offset split
    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [5:0]           ps;
        tlb_half_t            half;
    } tlb_hit_t;

endpackage

// File: verilog/mmu_pkg.sv
package mmu_pkg;

    // Exception codes
    localparam logic [5:0] ecode_pil  = 6'd1;
    localparam logic [5:0] ecode_pis  = 6'd2;
    localparam logic [5:0] ecode_pif  = 6'd3;
    localparam logic [5:0] ecode_pme  = 6'd4;
    localparam logic [5:0] ecode_ppi  = 6'd7;
    localparam logic [5:0] ecode_tlbr = 6'd63;

    // Direct mapping window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic       da;
        logic       pg;
        logic [1:0] plv;
        logic [9:0] asid;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } mmu_cfg_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        odd;     // va[12]
        logic [11:0] offset;
    } va_4k_t;

    typedef struct packed {
        logic [9:0]  vppn_hi;
        logic        odd;     // va[21]
        logic [20:0] offset;
    } va_4m_t;

    // Same address word seen as either page size
    typedef union packed {
        logic [31:0] addr;
        va_4k_t      pg4k;
        va_4m_t      pg4m;
    } va_u;

    typedef struct packed {
        logic valid;
        va_u  va;
        logic store;
    } xlate_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pa;
        logic        ex;
        logic [5:0]  ecode;
    } xlate_rsp_t;

endpackage

// File: verilog/tlb_array.sv
`timescale 1ns/1ps

module tlb_array (
    input  logic                                          clk,
    input  logic                                          rst,
    input  tlb_pkg::tlb_wr_t                              tlb_wr,
    input  tlb_pkg::tlb_inv_t                             inv,
    input  logic [tlb_pkg::tlb_idx_w-1:0]                 r_index,
    output tlb_pkg::tlb_entry_t                           r_entry,
    output tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0]    entries
);

    tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] mem;   // Payload, e kept apart
    logic [tlb_pkg::tlb_num-1:0]                ent_e;
    logic [tlb_pkg::tlb_num-1:0]                asid_eq;
    logic [tlb_pkg::tlb_num-1:0]                va_eq;
    logic [tlb_pkg::tlb_num-1:0]                kill;

    // Per entry compare against the invalidate command
    always_comb begin
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            asid_eq[i] = mem[i].asid == inv.asid;
            if (mem[i].ps == tlb_pkg::ps_4m) begin
                va_eq[i] = mem[i].vppn[18:9] == inv.vppn[18:9];
            end else begin
                va_eq[i] = mem[i].vppn == inv.vppn;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            case (inv.op)
                tlb_pkg::inv_all0,
                tlb_pkg::inv_all1:         kill[i] = 1'b1;
                tlb_pkg::inv_g1:           kill[i] = mem[i].g;
                tlb_pkg::inv_g0:           kill[i] = !mem[i].g;
                tlb_pkg::inv_g0_asid:      kill[i] = !mem[i].g && asid_eq[i];
                tlb_pkg::inv_g0_asid_va:   kill[i] = !mem[i].g && asid_eq[i] && va_eq[i];
                tlb_pkg::inv_g_or_asid_va: kill[i] = (mem[i].g || asid_eq[i]) && va_eq[i];
                default:                   kill[i] = 1'b0;  // Reserved ops
            endcase
        end
    end

    // Valid bits, write beats invalidate on its own index
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_e <= '0;
        end else begin
            if (inv.valid) begin
                ent_e <= ent_e & ~kill;
            end
            if (tlb_wr.we) begin
                ent_e[tlb_wr.index] <= tlb_wr.entry.e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr.we) begin
            mem[tlb_wr.index] <= tlb_wr.entry;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            entries[i]   = mem[i];
            entries[i].e = ent_e[i];
        end
    end

    assign r_entry = entries[r_index];  // Read port

endmodule

// File: verilog/tlb_match.sv
`timescale 1ns/1ps

module tlb_match (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] entries,
    input  mmu_pkg::va_u                               va,
    input  logic [9:0]                                 asid,
    output tlb_pkg::tlb_hit_t                          hit
);

    logic [tlb_pkg::tlb_num-1:0]   vppn_eq;
    logic [tlb_pkg::tlb_num-1:0]   match;
    logic                          found;
    logic [tlb_pkg::tlb_idx_w-1:0] index;
    tlb_pkg::tlb_entry_t           sel;
    logic                          odd;

    always_comb begin
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            // 4 MB pages compare only the upper vppn bits
            if (entries[i].ps == tlb_pkg::ps_4m) begin
                vppn_eq[i] = entries[i].vppn[18:9] == va.pg4m.vppn_hi;
            end else begin
                vppn_eq[i] = entries[i].vppn == va.pg4k.vppn;
            end
            match[i] = entries[i].e && (entries[i].g || entries[i].asid == asid)
                       && vppn_eq[i];
        end
    end

    // Lowest matching index wins
    always_comb begin
        found = 1'b0;
        index = '0;
        sel   = entries[0];
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            if (match[i] && !found) begin
                found = 1'b1;
                index = i[tlb_pkg::tlb_idx_w-1:0];
                sel   = entries[i];
            end
        end
    end

    // Even/odd bit sits just above the page offset
    assign odd = (sel.ps == tlb_pkg::ps_4m) ? va.pg4m.odd : va.pg4k.odd;

    always_comb begin
        hit.found = found;
        hit.index = index;
        hit.ps    = sel.ps;
        hit.half  = odd ? sel.p1 : sel.p0;
    end

endmodule

// File: verilog/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate #(
    parameter bit fetch = 1'b1   // Selects the fetch or the data fault set
) (
    input  logic                clk,
    input  logic                rst,
    input  mmu_pkg::mmu_cfg_t   cfg,
    input  mmu_pkg::xlate_req_t req,
    input  tlb_pkg::tlb_hit_t   hit,
    output mmu_pkg::xlate_rsp_t rsp
);

    logic        direct;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic [31:0] page_pa;
    logic [31:0] pa_n;
    logic        ex_n;
    logic [5:0]  ecode_n;

    function automatic logic win_hit(input mmu_pkg::dmw_t w, input logic [1:0] plv,
                                     input logic [2:0] seg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return plv_ok && w.vseg == seg;
    endfunction

    // pg clear with da clear is treated as direct too
    assign direct   = cfg.da || !cfg.pg;
    assign dmw0_hit = win_hit(cfg.dmw0, cfg.plv, req.va.addr[31:29]);
    assign dmw1_hit = win_hit(cfg.dmw1, cfg.plv, req.va.addr[31:29]);

    assign page_pa = (hit.ps == tlb_pkg::ps_4m) ?
                     {hit.half.ppn[19:9], req.va.pg4m.offset} :
                     {hit.half.ppn, req.va.pg4k.offset};

    always_comb begin
        ex_n    = 1'b0;
        ecode_n = '0;
        if (direct) begin
            pa_n = req.va.addr;
        end else if (dmw0_hit) begin
            pa_n = {cfg.dmw0.pseg, req.va.addr[28:0]};
        end else if (dmw1_hit) begin
            pa_n = {cfg.dmw1.pseg, req.va.addr[28:0]};
        end else begin
            pa_n = page_pa;     // Reported even on a fault
            if (!hit.found) begin
                ex_n    = 1'b1;
                ecode_n = mmu_pkg::ecode_tlbr;
            end else if (!hit.half.v) begin
                ex_n = 1'b1;
                if (fetch) begin
                    ecode_n = mmu_pkg::ecode_pif;
                end else if (req.store) begin
                    ecode_n = mmu_pkg::ecode_pis;
                end else begin
                    ecode_n = mmu_pkg::ecode_pil;
                end
            end else if (cfg.plv > hit.half.plv) begin
                ex_n    = 1'b1;
                ecode_n = mmu_pkg::ecode_ppi;
            end else if (!fetch && req.store && !hit.half.d) begin
                ex_n    = 1'b1;
                ecode_n = mmu_pkg::ecode_pme;   // Store to clean page
            end
        end
    end

    // Response register, one request per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
        end
        if (req.valid) begin
            rsp.pa    <= pa_n;
            rsp.ex    <= ex_n;
            rsp.ecode <= ecode_n;
        end
    end

endmodule

// File: verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  mmu_pkg::mmu_cfg_t             cfg,
    input  mmu_pkg::xlate_req_t           fetch_req,
    input  mmu_pkg::xlate_req_t           data_req,
    input  tlb_pkg::tlb_wr_t              tlb_wr,
    input  logic [tlb_pkg::tlb_idx_w-1:0] r_index,
    input  tlb_pkg::tlb_inv_t             inv,
    output mmu_pkg::xlate_rsp_t           fetch_rsp,
    output mmu_pkg::xlate_rsp_t           data_rsp,
    output tlb_pkg::tlb_entry_t           r_entry
);

    tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] entries;
    tlb_pkg::tlb_hit_t                          fetch_hit;
    tlb_pkg::tlb_hit_t                          data_hit;

    tlb_array u_tlb_array (
        .clk     (clk),
        .rst     (rst),
        .tlb_wr  (tlb_wr),
        .inv     (inv),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // Search port 0, instruction side
    tlb_match u_fetch_match (
        .entries (entries),
        .va      (fetch_req.va),
        .asid    (cfg.asid),
        .hit     (fetch_hit)
    );

    // Search port 1, load/store side
    tlb_match u_data_match (
        .entries (entries),
        .va      (data_req.va),
        .asid    (cfg.asid),
        .hit     (data_hit)
    );

    addr_xlate #(.fetch(1'b1)) u_fetch_xlate (
        .clk (clk),
        .rst (rst),
        .cfg (cfg),
        .req (fetch_req),
        .hit (fetch_hit),
        .rsp (fetch_rsp)
    );

    addr_xlate #(.fetch(1'b0)) u_data_xlate (
        .clk (clk),
        .rst (rst),
        .cfg (cfg),
        .req (data_req),
        .hit (data_hit),
        .rsp (data_rsp)
    );

endmodule

// File: sim/mmu_chk.sv
`timescale 1ns/1ps

module mmu_chk (
    input logic                clk,
    input logic                rst,
    input mmu_pkg::xlate_req_t fetch_req,
    input mmu_pkg::xlate_req_t data_req,
    input mmu_pkg::xlate_rsp_t fetch_rsp,
    input mmu_pkg::xlate_rsp_t data_rsp
);

    a_idle_after_rst: assert property (@(posedge clk)
        rst |=> !fetch_rsp.valid && !data_rsp.valid)
        else $error("response valid high right after reset");

    // A fault always carries a cause
    a_fetch_ecode: assert property (@(posedge clk) disable iff (rst)
        fetch_rsp.valid && fetch_rsp.ex |-> fetch_rsp.ecode != 6'd0)
        else $error("fetch_rsp.ex set with a zero ecode");
    a_data_ecode: assert property (@(posedge clk) disable iff (rst)
        data_rsp.valid && data_rsp.ex |-> data_rsp.ecode != 6'd0)
        else $error("data_rsp.ex set with a zero ecode");

    a_fetch_lat: assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid |=> fetch_rsp.valid)
        else $error("fetch_rsp.valid missing one cycle after fetch_req.valid");
    a_fetch_src: assert property (@(posedge clk) disable iff (rst)
        fetch_rsp.valid |-> $past(fetch_req.valid))
        else $error("fetch_rsp.valid without a fetch request");
    a_data_lat: assert property (@(posedge clk) disable iff (rst)
        data_req.valid |=> data_rsp.valid)
        else $error("data_rsp.valid missing one cycle after data_req.valid");
    a_data_src: assert property (@(posedge clk) disable iff (rst)
        data_rsp.valid |-> $past(data_req.valid))
        else $error("data_rsp.valid without a data request");

endmodule

bind mmu_top mmu_chk i_chk (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .data_req  (data_req),
    .fetch_rsp (fetch_rsp),
    .data_rsp  (data_rsp)
);

// File: sim/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    typedef enum logic [2:0] {
        k_idle, k_cfg, k_wr, k_inv, k_fetch, k_data, k_read
    } row_kind_t;

    // One table row, stimulus and expected result
    typedef struct packed {
        row_kind_t           kind;
        mmu_pkg::mmu_cfg_t   cfg;
        logic [31:0]         va;
        logic                store;
        logic [3:0]          idx;
        tlb_pkg::tlb_entry_t entry;
        tlb_pkg::tlb_inv_t   inv;
        logic [31:0]         exp_pa;
        logic [5:0]          exp_ecode;   // Zero means no fault
    } row_t;

    logic                  clk;
    logic                  rst;
    mmu_pkg::mmu_cfg_t     cfg;
    mmu_pkg::xlate_req_t   fetch_req;
    mmu_pkg::xlate_req_t   data_req;
    tlb_pkg::tlb_wr_t      tlb_wr;
    logic [3:0]            r_index;
    tlb_pkg::tlb_inv_t     inv;
    mmu_pkg::xlate_rsp_t   fetch_rsp;
    mmu_pkg::xlate_rsp_t   data_rsp;
    tlb_pkg::tlb_entry_t   r_entry;

    row_t                  rows[$];
    row_t                  prev;
    tlb_pkg::tlb_entry_t   e0, e1, e2, e3, e0_dead;
    int                    cycles = 0;

    mmu_top i_mmu_top (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .tlb_wr    (tlb_wr),
        .r_index   (r_index),
        .inv       (inv),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .r_entry   (r_entry)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == rows.size() + 40) begin
            $display("Timeout: run did not finish within %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic tlb_pkg::tlb_half_t make_half(input logic [19:0] ppn,
                                                     input logic [1:0] plv,
                                                     input logic d, input logic v);
        tlb_pkg::tlb_half_t h;
        h.ppn = ppn;
        h.plv = plv;
        h.mat = 2'd1;
        h.d   = d;
        h.v   = v;
        return h;
    endfunction

    function automatic tlb_pkg::tlb_entry_t make_entry(input logic [18:0] vppn,
            input logic [5:0] ps, input logic [9:0] asid, input logic g,
            input tlb_pkg::tlb_half_t p0, input tlb_pkg::tlb_half_t p1);
        tlb_pkg::tlb_entry_t ent;
        ent.e    = 1'b1;
        ent.vppn = vppn;
        ent.ps   = ps;
        ent.asid = asid;
        ent.g    = g;
        ent.p0   = p0;
        ent.p1   = p1;
        return ent;
    endfunction

    // Windows: vseg 5 for plv 0 only, vseg 6 for both levels
    function automatic row_t cfg_row(input logic da, input logic [1:0] plv,
                                     input logic [9:0] asid);
        row_t r;
        r = '0;
        r.kind     = k_cfg;
        r.cfg.da   = da;
        r.cfg.pg   = !da;
        r.cfg.plv  = plv;
        r.cfg.asid = asid;
        r.cfg.dmw0 = '{plv0: 1'b1, plv3: 1'b0, mat: 2'd1, pseg: 3'd0, vseg: 3'd5};
        r.cfg.dmw1 = '{plv0: 1'b1, plv3: 1'b1, mat: 2'd1, pseg: 3'd2, vseg: 3'd6};
        return r;
    endfunction

    function automatic row_t entry_row(input row_kind_t kind, input logic [3:0] idx,
                                       input tlb_pkg::tlb_entry_t ent);
        row_t r;
        r = '0;
        r.kind  = kind;
        r.idx   = idx;
        r.entry = ent;
        return r;
    endfunction

    function automatic row_t inv_row(input logic [4:0] op, input logic [9:0] asid,
                                     input logic [18:0] vppn);
        row_t r;
        r = '0;
        r.kind = k_inv;
        r.inv  = '{valid: 1'b1, op: op, asid: asid, vppn: vppn};
        return r;
    endfunction

    function automatic row_t xlate_row(input row_kind_t kind, input logic [31:0] va,
            input logic store, input logic [31:0] pa, input logic [5:0] ecode);
        row_t r;
        r = '0;
        r.kind      = kind;
        r.va        = va;
        r.store     = store;
        r.exp_pa    = pa;
        r.exp_ecode = ecode;
        return r;
    endfunction

    task automatic build_table();
        e0 = make_entry(19'h08000, tlb_pkg::ps_4k, 10'd5, 1'b0,
                        make_half(20'h12345, 2'd0, 1'b1, 1'b1),
                        make_half(20'h2abcd, 2'd3, 1'b0, 1'b1));
        e1 = make_entry(19'h40000, tlb_pkg::ps_4m, 10'd0, 1'b1,
                        make_half(20'h04000, 2'd0, 1'b1, 1'b1),
                        make_half(20'h0ae00, 2'd0, 1'b1, 1'b0));
        e2 = make_entry(19'h00180, tlb_pkg::ps_4k, 10'd9, 1'b0,
                        make_half(20'h00777, 2'd0, 1'b1, 1'b1),
                        make_half(20'h00888, 2'd0, 1'b1, 1'b1));
        e3 = make_entry(19'h08002, tlb_pkg::ps_4k, 10'd5, 1'b0,
                        make_half(20'h33333, 2'd3, 1'b1, 1'b1),
                        make_half(20'h44444, 2'd3, 1'b1, 1'b1));
        e0_dead   = e0;
        e0_dead.e = 1'b0;

        rows.push_back(cfg_row(1'b1, 2'd0, 10'd5));     // Direct mode
        rows.push_back(xlate_row(k_fetch, 32'h1234_5678, 1'b0, 32'h1234_5678, 6'd0));
        rows.push_back(xlate_row(k_data, 32'hdead_beec, 1'b1, 32'hdead_beec, 6'd0));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd5));
        rows.push_back(xlate_row(k_fetch, 32'ha123_4567, 1'b0, 32'h0123_4567, 6'd0));
        rows.push_back(xlate_row(k_data, 32'hc000_0010, 1'b0, 32'h4000_0010, 6'd0));
        rows.push_back(cfg_row(1'b0, 2'd3, 10'd5));
        rows.push_back(xlate_row(k_fetch, 32'ha000_0000, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
        rows.push_back(xlate_row(k_data, 32'hc000_0010, 1'b1, 32'h4000_0010, 6'd0));
        rows.push_back(entry_row(k_wr, 4'd0, e0));
        rows.push_back(entry_row(k_wr, 4'd1, e1));
        rows.push_back(entry_row(k_wr, 4'd5, e2));
        rows.push_back(entry_row(k_wr, 4'd7, e3));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd5));
        rows.push_back(entry_row(k_read, 4'd0, e0));
        rows.push_back(entry_row(k_read, 4'd1, e1));
        rows.push_back(entry_row(k_read, 4'd5, e2));
        rows.push_back(xlate_row(k_fetch, 32'h1000_0abc, 1'b0, 32'h1234_5abc, 6'd0));
        rows.push_back(xlate_row(k_data, 32'h1000_1123, 1'b0, 32'h2abc_d123, 6'd0));
        rows.push_back(xlate_row(k_data, 32'h1000_0004, 1'b1, 32'h1234_5004, 6'd0));
        rows.push_back(xlate_row(k_fetch, 32'h8012_3456, 1'b0, 32'h0412_3456, 6'd0));
        rows.push_back(xlate_row(k_fetch, 32'h0030_0000, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
        rows.push_back(xlate_row(k_fetch, 32'h8032_1000, 1'b0, 32'h0af2_1000, mmu_pkg::ecode_pif));
        rows.push_back(xlate_row(k_data, 32'h8020_0040, 1'b0, 32'h0ae0_0040, mmu_pkg::ecode_pil));
        rows.push_back(xlate_row(k_data, 32'h8020_0040, 1'b1, 32'h0ae0_0040, mmu_pkg::ecode_pis));
        rows.push_back(xlate_row(k_data, 32'h1000_1010, 1'b1, 32'h2abc_d010, mmu_pkg::ecode_pme));
        rows.push_back(cfg_row(1'b0, 2'd3, 10'd5));
        rows.push_back(xlate_row(k_data, 32'h1000_0abc, 1'b0, 32'h1234_5abc, mmu_pkg::ecode_ppi));
        rows.push_back(xlate_row(k_data, 32'h1000_1123, 1'b0, 32'h2abc_d123, 6'd0));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd9));
        rows.push_back(xlate_row(k_fetch, 32'h0030_0004, 1'b0, 32'h0077_7004, 6'd0));
        rows.push_back(inv_row(tlb_pkg::inv_g0_asid_va, 10'd5, 19'h08000));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd5));
        rows.push_back(xlate_row(k_fetch, 32'h1000_0abc, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
        rows.push_back(xlate_row(k_fetch, 32'h1000_4010, 1'b0, 32'h3333_3010, 6'd0));
        rows.push_back(entry_row(k_read, 4'd0, e0_dead));
        rows.push_back(inv_row(tlb_pkg::inv_g0_asid, 10'd9, 19'h0));
        rows.push_back(xlate_row(k_fetch, 32'h8012_3456, 1'b0, 32'h0412_3456, 6'd0));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd9));
        rows.push_back(xlate_row(k_fetch, 32'h0030_0004, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
        rows.push_back(inv_row(tlb_pkg::inv_g1, 10'd0, 19'h0));
        rows.push_back(xlate_row(k_fetch, 32'h8012_3456, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
        rows.push_back(cfg_row(1'b0, 2'd0, 10'd5));
        rows.push_back(xlate_row(k_data, 32'h1000_4010, 1'b0, 32'h3333_3010, 6'd0));
        rows.push_back(xlate_row(k_data, 32'h8020_0040, 1'b0, 32'h0, mmu_pkg::ecode_tlbr));
    endtask

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_rsp(input string name, input mmu_pkg::xlate_rsp_t got,
                             input row_t r);
        logic exp_ex;
        exp_ex = r.exp_ecode != 6'd0;
        assert (got.valid) else begin
            $display("[FAIL] %0t %s.valid got 0 expected 1", $time, name);
            stop_with_failure();
        end
        assert (got.ex == exp_ex) else begin
            $display("[FAIL] %0t %s.ex got %0b expected %0b", $time, name, got.ex, exp_ex);
            stop_with_failure();
        end
        if (exp_ex) begin
            assert (got.ecode == r.exp_ecode) else begin
                $display("[FAIL] %0t %s.ecode got %0d expected %0d", $time, name,
                         got.ecode, r.exp_ecode);
                stop_with_failure();
            end
        end
        // A refill has no page, so no address to compare
        if (r.exp_ecode != mmu_pkg::ecode_tlbr) begin
            assert (got.pa == r.exp_pa) else begin
                $display("[FAIL] %0t %s.pa got %h expected %h", $time, name,
                         got.pa, r.exp_pa);
                stop_with_failure();
            end
        end
    endtask

    task automatic check_pending(input row_t r);
        if (r.kind == k_fetch) begin
            check_rsp("fetch_rsp", fetch_rsp, r);
        end else if (r.kind == k_data) begin
            check_rsp("data_rsp", data_rsp, r);
        end
    endtask

    task automatic check_entry(input row_t r);
        assert (r_entry == r.entry) else begin
            $display("[FAIL] %0t r_entry got %h expected %h", $time, r_entry, r.entry);
            stop_with_failure();
        end
    endtask

    // Strobes last one cycle, cfg and r_index hold
    task automatic apply_row(input row_t r);
        fetch_req = '0;
        data_req  = '0;
        tlb_wr    = '0;
        inv       = '0;
        case (r.kind)
            k_cfg: cfg = r.cfg;
            k_wr: begin
                tlb_wr.we    = 1'b1;
                tlb_wr.index = r.idx;
                tlb_wr.entry = r.entry;
            end
            k_inv: inv = r.inv;
            k_fetch: begin
                fetch_req.valid   = 1'b1;
                fetch_req.va.addr = r.va;
                fetch_req.store   = r.store;
            end
            k_data: begin
                data_req.valid   = 1'b1;
                data_req.va.addr = r.va;
                data_req.store   = r.store;
            end
            k_read: r_index = r.idx;
            default: ;
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        cfg       = '0;
        fetch_req = '0;
        data_req  = '0;
        tlb_wr    = '0;
        r_index   = '0;
        inv       = '0;
        prev      = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            check_pending(prev);    // Response to the row before
            apply_row(rows[i]);
            if (rows[i].kind == k_read) begin
                #1;
                check_entry(rows[i]);
            end
            prev = rows[i];
        end
        @(posedge clk);
        #1;
        check_pending(prev);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: files.f
verilog/tlb_pkg.sv
verilog/mmu_pkg.sv
verilog/tlb_array.sv
verilog/tlb_match.sv
verilog/addr_xlate.sv
verilog/mmu_top.sv
sim/mmu_chk.sv
sim/mmu_tb.sv

// File: Makefile
# Verilator build and run of the MMU testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build mmu_tb with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
		--top-module mmu_tb -Mdir $(OBJ_DIR) -f files.f
	./$(OBJ_DIR)/Vmmu_tb

clean:
	rm -rf $(OBJ_DIR)
